// ==== common/mmm_width_pkg.sv ====
/* montgomery multiplier widths
   limb, operand and product sizes plus the arithmetic types */

package mmm_width_pkg;

    ////////////////////////////////////////////////////////////
    // operand and limb geometry
    ////////////////////////////////////////////////////////////
    localparam int OPERAND_W = 256;
    localparam int LIMB_W    = 87;
    localparam int LIMB_CNT  = 3;

    // radix exponent, R = 2**R_W
    localparam int R_W       = LIMB_W * LIMB_CNT;

    // sum of two limbs keeps its carry
    localparam int PRE_W     = LIMB_W + 1;

    // result lies in [0, 2m) so one bit above the operand
    localparam int RESULT_W  = OPERAND_W + 1;

    ////////////////////////////////////////////////////////////
    // arithmetic types
    ////////////////////////////////////////////////////////////
    typedef logic [LIMB_W-1:0]     limb_t;
    typedef logic [PRE_W-1:0]      pre_t;
    typedef logic [2*PRE_W-1:0]    limb_prod_t;

    // operand split into limbs, hi limb first
    typedef struct packed {
        limb_t hi;
        limb_t mid;
        limb_t lo;
    } limbs3_t;

    typedef logic [2*R_W-1:0]      wide_t;
    typedef logic [RESULT_W-1:0]   result_t;

endpackage

// ==== common/mmm_pipe_pkg.sv ====
/* montgomery pipeline timing
   stage latencies, alignment delays and the top-level input word */

package mmm_pipe_pkg;

    localparam int LIMB_MUL_LAT  = 3;
    localparam int PRODUCT_LAT   = 5;
    localparam int QUOTIENT_LAT  = 4;
    localparam int REDUCE_LAT    = 6;
    localparam int TOTAL_LAT     = PRODUCT_LAT + QUOTIENT_LAT + REDUCE_LAT;

    // m' meets T low limbs at the quotient stage
    localparam int M_PRIME_DELAY = PRODUCT_LAT;
    // m meets q at the reduction stage
    localparam int M_DELAY       = PRODUCT_LAT + QUOTIENT_LAT;
    // T meets q*m at the final addition
    localparam int T_DELAY       = QUOTIENT_LAT + PRODUCT_LAT;

    // one operand set per cycle
    typedef struct packed {
        mmm_width_pkg::limbs3_t a;
        mmm_width_pkg::limbs3_t b;
        mmm_width_pkg::limbs3_t m;
        mmm_width_pkg::limbs3_t m_prime;
    } mmm_operands_t;

endpackage

// ==== verilog/mmm_limb_mul.sv ====
/* pipelined limb multiplier
   88x88 product in three stages, split into two half-width partials */

`timescale 1ns/100ps

module mmm_limb_mul (
    input  logic                             i_clk,
    input  logic                             i_rstn,
    input  mmm_width_pkg::pre_t              i_a,
    input  mmm_width_pkg::pre_t              i_b,
    output mmm_width_pkg::limb_prod_t        o_prod
);

    mmm_width_pkg::pre_t a_q;
    mmm_width_pkg::pre_t b_q;

    // a times each half of b
    logic [mmm_width_pkg::PRE_W+mmm_width_pkg::PRE_W/2-1:0] part_lo;
    logic [mmm_width_pkg::PRE_W+mmm_width_pkg::PRE_W/2-1:0] part_hi;

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            a_q     <= '0;
            b_q     <= '0;
            part_lo <= '0;
            part_hi <= '0;
            o_prod  <= '0;
        end else begin
            // stage 1 operand capture
            a_q     <= i_a;
            b_q     <= i_b;
            // stage 2 partial products
            part_lo <= a_q * b_q[mmm_width_pkg::PRE_W/2-1:0];
            part_hi <= a_q * b_q[mmm_width_pkg::PRE_W-1:mmm_width_pkg::PRE_W/2];
            // stage 3 recombine
            o_prod  <= mmm_width_pkg::limb_prod_t'(part_lo)
                     + (mmm_width_pkg::limb_prod_t'(part_hi) << (mmm_width_pkg::PRE_W/2));
        end
    end

endmodule

// ==== verilog/mmm_delay_line.sv ====
/* alignment delay line
   resettable shift register, exactly DEPTH cycles */

`timescale 1ns/100ps

module mmm_delay_line #(
    parameter int DEPTH = 1,
    parameter int WIDTH = 1
) (
    input  logic             i_clk,
    input  logic             i_rstn,
    input  logic [WIDTH-1:0] i_data,
    output logic [WIDTH-1:0] o_data
);

    logic [WIDTH-1:0] stage_q [DEPTH];

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage_q[i] <= '0;
            end
        end else begin
            stage_q[0] <= i_data;
            for (int i = 1; i < DEPTH; i++) begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    assign o_data = stage_q[DEPTH-1];

endmodule

// ==== mmm_core/mmm_product_stage.sv ====
/* three-limb karatsuba multiplier
   full 522-bit product in five cycles, one new pair per cycle */

`timescale 1ns/100ps

module mmm_product_stage (
    input  logic                      i_clk,
    input  logic                      i_rstn,
    input  logic                      i_valid,
    input  mmm_width_pkg::limbs3_t    i_x,
    input  mmm_width_pkg::limbs3_t    i_y,
    output logic                      o_valid,
    output mmm_width_pkg::wide_t      o_prod
);

    // 0..2 plain limbs, 3 = l0+l1, 4 = l0+l2, 5 = l1+l2
    mmm_width_pkg::pre_t [5:0]  x_pre;
    mmm_width_pkg::pre_t [5:0]  y_pre;
    mmm_width_pkg::limb_prod_t  prod [6];
    mmm_width_pkg::wide_t       t_sum;

    ////////////////////////////////////////////////////////////
    // pre-add register
    ////////////////////////////////////////////////////////////
    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            x_pre <= '0;
            y_pre <= '0;
        end else begin
            x_pre[0] <= mmm_width_pkg::pre_t'(i_x.lo);
            x_pre[1] <= mmm_width_pkg::pre_t'(i_x.mid);
            x_pre[2] <= mmm_width_pkg::pre_t'(i_x.hi);
            x_pre[3] <= mmm_width_pkg::pre_t'(i_x.lo) + mmm_width_pkg::pre_t'(i_x.mid);
            x_pre[4] <= mmm_width_pkg::pre_t'(i_x.lo) + mmm_width_pkg::pre_t'(i_x.hi);
            x_pre[5] <= mmm_width_pkg::pre_t'(i_x.mid) + mmm_width_pkg::pre_t'(i_x.hi);
            y_pre[0] <= mmm_width_pkg::pre_t'(i_y.lo);
            y_pre[1] <= mmm_width_pkg::pre_t'(i_y.mid);
            y_pre[2] <= mmm_width_pkg::pre_t'(i_y.hi);
            y_pre[3] <= mmm_width_pkg::pre_t'(i_y.lo) + mmm_width_pkg::pre_t'(i_y.mid);
            y_pre[4] <= mmm_width_pkg::pre_t'(i_y.lo) + mmm_width_pkg::pre_t'(i_y.hi);
            y_pre[5] <= mmm_width_pkg::pre_t'(i_y.mid) + mmm_width_pkg::pre_t'(i_y.hi);
        end
    end

    ////////////////////////////////////////////////////////////
    // six limb multipliers
    ////////////////////////////////////////////////////////////
    for (genvar k = 0; k < 6; k++) begin : g_mul
        mmm_limb_mul u_mul (
            .i_clk  (i_clk),
            .i_rstn (i_rstn),
            .i_a    (x_pre[k]),
            .i_b    (y_pre[k]),
            .o_prod (prod[k])
        );
    end

    // cross terms recovered by subtracting the plain products,
    // modular wrap in 522 bits cancels out in the final sum
    always_comb begin
        mmm_width_pkg::wide_t p0;
        mmm_width_pkg::wide_t p1;
        mmm_width_pkg::wide_t p2;
        mmm_width_pkg::wide_t cross01;
        mmm_width_pkg::wide_t cross02;
        mmm_width_pkg::wide_t cross12;
        p0      = mmm_width_pkg::wide_t'(prod[0]);
        p1      = mmm_width_pkg::wide_t'(prod[1]);
        p2      = mmm_width_pkg::wide_t'(prod[2]);
        cross01 = mmm_width_pkg::wide_t'(prod[3]) - p0 - p1;
        // middle column also carries l1*l1
        cross02 = mmm_width_pkg::wide_t'(prod[4]) - p0 - p2 + p1;
        cross12 = mmm_width_pkg::wide_t'(prod[5]) - p1 - p2;
        t_sum   = p0
                + (cross01 << mmm_width_pkg::LIMB_W)
                + (cross02 << (2*mmm_width_pkg::LIMB_W))
                + (cross12 << (3*mmm_width_pkg::LIMB_W))
                + (p2      << (4*mmm_width_pkg::LIMB_W));
    end

    // combine register
    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            o_prod <= '0;
        end else begin
            o_prod <= t_sum;
        end
    end

    mmm_delay_line #(
        .DEPTH (mmm_pipe_pkg::PRODUCT_LAT),
        .WIDTH (1)
    ) u_valid_dly (
        .i_clk  (i_clk),
        .i_rstn (i_rstn),
        .i_data (i_valid),
        .o_data (o_valid)
    );

endmodule

// ==== mmm_core/mmm_quotient_stage.sv ====
/* montgomery quotient
   q = (T mod R) * m' mod R from the five terms that land below R */

`timescale 1ns/100ps

module mmm_quotient_stage (
    input  logic                      i_clk,
    input  logic                      i_rstn,
    input  logic                      i_valid,
    input  mmm_width_pkg::limbs3_t    i_t_low,
    input  mmm_width_pkg::limbs3_t    i_m_prime,
    output logic                      o_valid,
    output mmm_width_pkg::limbs3_t    o_q
);

    // 0 u0*m0, 1 u1*m1, 2 u0*m2, 3 u2*m0, 4 (u0+u1)*(m0+m1)
    mmm_width_pkg::pre_t [4:0]  u_pre;
    mmm_width_pkg::pre_t [4:0]  m_pre;
    mmm_width_pkg::limb_prod_t  prod [5];
    logic [mmm_width_pkg::R_W-1:0] q_sum;

    // pre-adds feed the multipliers directly
    assign u_pre[0] = mmm_width_pkg::pre_t'(i_t_low.lo);
    assign u_pre[1] = mmm_width_pkg::pre_t'(i_t_low.mid);
    assign u_pre[2] = mmm_width_pkg::pre_t'(i_t_low.lo);
    assign u_pre[3] = mmm_width_pkg::pre_t'(i_t_low.hi);
    assign u_pre[4] = mmm_width_pkg::pre_t'(i_t_low.lo) + mmm_width_pkg::pre_t'(i_t_low.mid);

    assign m_pre[0] = mmm_width_pkg::pre_t'(i_m_prime.lo);
    assign m_pre[1] = mmm_width_pkg::pre_t'(i_m_prime.mid);
    assign m_pre[2] = mmm_width_pkg::pre_t'(i_m_prime.hi);
    assign m_pre[3] = mmm_width_pkg::pre_t'(i_m_prime.lo);
    assign m_pre[4] = mmm_width_pkg::pre_t'(i_m_prime.lo) + mmm_width_pkg::pre_t'(i_m_prime.mid);

    for (genvar k = 0; k < 5; k++) begin : g_mul
        mmm_limb_mul u_mul (
            .i_clk  (i_clk),
            .i_rstn (i_rstn),
            .i_a    (u_pre[k]),
            .i_b    (m_pre[k]),
            .o_prod (prod[k])
        );
    end

    ////////////////////////////////////////////////////////////
    // combine, everything mod 2**R_W
    ////////////////////////////////////////////////////////////
    always_comb begin
        logic [mmm_width_pkg::R_W-1:0] col1;
        logic [mmm_width_pkg::R_W-1:0] col2;
        col1  = mmm_width_pkg::R_W'(prod[4]) - mmm_width_pkg::R_W'(prod[0])
              - mmm_width_pkg::R_W'(prod[1]);
        col2  = mmm_width_pkg::R_W'(prod[2]) + mmm_width_pkg::R_W'(prod[3])
              + mmm_width_pkg::R_W'(prod[1]);
        q_sum = mmm_width_pkg::R_W'(prod[0])
              + (col1 << mmm_width_pkg::LIMB_W)
              + (col2 << (2*mmm_width_pkg::LIMB_W));
    end

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            o_q <= '0;
        end else begin
            o_q <= mmm_width_pkg::limbs3_t'(q_sum);
        end
    end

    mmm_delay_line #(
        .DEPTH (mmm_pipe_pkg::QUOTIENT_LAT),
        .WIDTH (1)
    ) u_valid_dly (
        .i_clk  (i_clk),
        .i_rstn (i_rstn),
        .i_data (i_valid),
        .o_data (o_valid)
    );

endmodule

// ==== mmm_core/mmm_reduce_stage.sv ====
/* montgomery reduction
   (T + q*m) / R, registered one cycle after the q*m product */

`timescale 1ns/100ps

module mmm_reduce_stage (
    input  logic                      i_clk,
    input  logic                      i_rstn,
    input  logic                      i_valid,
    input  mmm_width_pkg::limbs3_t    i_q,
    input  mmm_width_pkg::limbs3_t    i_m,
    // T arrives aligned with the q*m product, not with i_q
    input  mmm_width_pkg::wide_t      i_t,
    output logic                      o_valid,
    output mmm_width_pkg::result_t    o_result
);

    logic                  qm_valid;
    mmm_width_pkg::wide_t  qm_prod;
    mmm_width_pkg::wide_t  red_sum;

    mmm_product_stage u_qm (
        .i_clk   (i_clk),
        .i_rstn  (i_rstn),
        .i_valid (i_valid),
        .i_x     (i_q),
        .i_y     (i_m),
        .o_valid (qm_valid),
        .o_prod  (qm_prod)
    );

    // low R_W bits cancel since q*m = -T mod R
    assign red_sum = qm_prod + i_t;

    ////////////////////////////////////////////////////////////
    // final addition register
    ////////////////////////////////////////////////////////////
    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            o_valid  <= 1'b0;
            o_result <= '0;
        end else begin
            o_valid  <= qm_valid;
            o_result <= red_sum[mmm_width_pkg::R_W +: mmm_width_pkg::RESULT_W];
        end
    end

endmodule

// ==== mmm_core/mmm_montgomery_top.sv ====
/* montgomery multiplier top
   a*b*R^-1 mod m, fully pipelined, fixed 15-cycle latency */

`timescale 1ns/100ps

module mmm_montgomery_top (
    input  logic                         i_clk,
    input  logic                         i_rstn,
    input  logic                         i_valid,
    input  mmm_pipe_pkg::mmm_operands_t  i_operands,
    output logic                         o_valid,
    output mmm_width_pkg::result_t       o_result
);

    logic                    t_valid;
    mmm_width_pkg::wide_t    t_prod;
    mmm_width_pkg::wide_t    t_dly;
    logic                    q_valid;
    mmm_width_pkg::limbs3_t  q;
    mmm_width_pkg::limbs3_t  m_prime_dly;
    mmm_width_pkg::limbs3_t  m_dly;

    ////////////////////////////////////////////////////////////
    // step 1, T = a*b
    ////////////////////////////////////////////////////////////
    mmm_product_stage u_ab (
        .i_clk   (i_clk),
        .i_rstn  (i_rstn),
        .i_valid (i_valid),
        .i_x     (i_operands.a),
        .i_y     (i_operands.b),
        .o_valid (t_valid),
        .o_prod  (t_prod)
    );

    ////////////////////////////////////////////////////////////
    // step 2, q from the low limbs of T
    ////////////////////////////////////////////////////////////
    mmm_delay_line #(
        .DEPTH (mmm_pipe_pkg::M_PRIME_DELAY),
        .WIDTH (mmm_width_pkg::R_W)
    ) u_m_prime_dly (
        .i_clk  (i_clk),
        .i_rstn (i_rstn),
        .i_data (i_operands.m_prime),
        .o_data (m_prime_dly)
    );

    mmm_quotient_stage u_quot (
        .i_clk     (i_clk),
        .i_rstn    (i_rstn),
        .i_valid   (t_valid),
        .i_t_low   (mmm_width_pkg::limbs3_t'(t_prod[mmm_width_pkg::R_W-1:0])),
        .i_m_prime (m_prime_dly),
        .o_valid   (q_valid),
        .o_q       (q)
    );

    ////////////////////////////////////////////////////////////
    // step 3, reduction
    ////////////////////////////////////////////////////////////
    mmm_delay_line #(
        .DEPTH (mmm_pipe_pkg::M_DELAY),
        .WIDTH (mmm_width_pkg::R_W)
    ) u_m_dly (
        .i_clk  (i_clk),
        .i_rstn (i_rstn),
        .i_data (i_operands.m),
        .o_data (m_dly)
    );

    // T waits for q*m to leave the reduction multiplier
    mmm_delay_line #(
        .DEPTH (mmm_pipe_pkg::T_DELAY),
        .WIDTH (2*mmm_width_pkg::R_W)
    ) u_t_dly (
        .i_clk  (i_clk),
        .i_rstn (i_rstn),
        .i_data (t_prod),
        .o_data (t_dly)
    );

    mmm_reduce_stage u_reduce (
        .i_clk    (i_clk),
        .i_rstn   (i_rstn),
        .i_valid  (q_valid),
        .i_q      (q),
        .i_m      (m_dly),
        .i_t      (t_dly),
        .o_valid  (o_valid),
        .o_result (o_result)
    );

endmodule

// ==== verification/mmm_props.sv ====
/* montgomery multiplier properties
   latency, reset and result range of the top level */

`timescale 1ns/100ps

module mmm_props (
    input  logic                         i_clk,
    input  logic                         i_rstn,
    input  logic                         i_valid,
    input  mmm_pipe_pkg::mmm_operands_t  i_operands,
    input  logic                         o_valid,
    input  mmm_width_pkg::result_t       o_result
);

    // bubble pattern survives the pipeline
    valid_latency: assert property (@(posedge i_clk) disable iff (!i_rstn)
        o_valid == $past(i_valid, mmm_pipe_pkg::TOTAL_LAT))
        else $error("o_valid does not follow i_valid by the pipeline latency");

    valid_in_reset: assert property (@(posedge i_clk)
        !i_rstn |-> !o_valid)
        else $error("o_valid high during reset");

    // result in [0, 2m) for the modulus that entered with it
    result_range: assert property (@(posedge i_clk) disable iff (!i_rstn)
        o_valid |-> ({6'b0, o_result}
                     < {1'b0, $past(i_operands.m, mmm_pipe_pkg::TOTAL_LAT), 1'b0}))
        else $error("o_result not below twice the modulus");

endmodule

// ==== verification/mmm_tb.sv ====
/* montgomery multiplier testbench
   directed tests checked against a wide-vector model of a*b*R^-1 mod m */

`timescale 1ns/100ps

module mmm_tb;

    localparam int CLK_PERIOD  = 40;
    localparam int DRIVE_DLY   = 2;
    localparam int RST_CYCLES  = 3;
    localparam int IDLE_CYCLES = 10;
    localparam int RAND_CNT    = 20;
    localparam int LAT         = mmm_pipe_pkg::TOTAL_LAT;
    localparam logic [15:0] BUBBLE_PAT = 16'b1011_0010_1110_0101;
    localparam int TEST_CYCLES = RST_CYCLES + IDLE_CYCLES + (1 + LAT) + (2 + LAT)
                               + (RAND_CNT + LAT) + (16 + LAT);
    localparam int WATCH_NS    = (TEST_CYCLES + LAT) * 2 * CLK_PERIOD;

    typedef logic [599:0] big_t;
    localparam big_t R_MASK = (big_t'(1) << mmm_width_pkg::R_W) - 1;
    // 2**256 - 189
    localparam logic [255:0] M_EDGE = 256'h0 - 256'd189;

    logic                         i_clk;
    logic                         i_rstn;
    logic                         i_valid;
    mmm_pipe_pkg::mmm_operands_t  i_operands;
    logic                         o_valid;
    mmm_width_pkg::result_t       o_result;

    int seed = 32'h676f4a7b;
    int errors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    mmm_width_pkg::result_t exp_q[$];
    mmm_width_pkg::result_t last_result;
    logic [LAT-1:0] valid_hist = '0;

    mmm_montgomery_top DUT (
        .i_clk      (i_clk),
        .i_rstn     (i_rstn),
        .i_valid    (i_valid),
        .i_operands (i_operands),
        .o_valid    (o_valid),
        .o_result   (o_result)
    );

    bind mmm_montgomery_top mmm_props u_props (
        .i_clk      (i_clk),
        .i_rstn     (i_rstn),
        .i_valid    (i_valid),
        .i_operands (i_operands),
        .o_valid    (o_valid),
        .o_result   (o_result)
    );

    initial begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD/2) i_clk = ~i_clk;
    end

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////
    // newton step doubles the correct low bits each round
    function automatic big_t neg_inverse(input big_t m);
        big_t x;
        x = 1;
        for (int i = 0; i < 9; i++) begin
            x = (x * ((big_t'(2) - m * x) & R_MASK)) & R_MASK;
        end
        return (R_MASK + 1 - x) & R_MASK;
    endfunction

    function automatic mmm_width_pkg::result_t model_result(input big_t a, input big_t b,
                                                           input big_t m, input big_t mp);
        big_t t;
        big_t q;
        big_t s;
        t = a * b;
        q = ((t & R_MASK) * mp) & R_MASK;
        s = (t + q * m) >> mmm_width_pkg::R_W;
        return s[mmm_width_pkg::RESULT_W-1:0];
    endfunction

    function automatic logic [255:0] rand256();
        logic [255:0] v;
        for (int i = 0; i < 8; i++) begin
            v[i*32 +: 32] = $random(seed);
        end
        return v;
    endfunction

    ////////////////////////////////////////////////////////////
    // compare tasks and output monitor
    ////////////////////////////////////////////////////////////
    task automatic check_result(input string name, input mmm_width_pkg::result_t got,
                                input mmm_width_pkg::result_t exp);
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_valid(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // o_valid must repeat i_valid LAT cycles later
    initial begin
        forever begin
            @(negedge i_clk);
            check_valid("o_valid", o_valid, valid_hist[LAT-1]);
            valid_hist = {valid_hist[LAT-2:0], i_valid};
            if (o_valid) begin
                last_result = o_result;
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("o_valid was high with no result outstanding at %0t", $time);
                end else begin
                    check_result("o_result", o_result, exp_q.pop_front());
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////
    task automatic send(input logic [255:0] a, input logic [255:0] b, input logic [255:0] m);
        big_t mp;
        mp = neg_inverse(big_t'(m));
        @(posedge i_clk);
        #DRIVE_DLY;
        i_valid            = 1'b1;
        i_operands.a       = mmm_width_pkg::limbs3_t'({5'b0, a});
        i_operands.b       = mmm_width_pkg::limbs3_t'({5'b0, b});
        i_operands.m       = mmm_width_pkg::limbs3_t'({5'b0, m});
        i_operands.m_prime = mmm_width_pkg::limbs3_t'(mp[mmm_width_pkg::R_W-1:0]);
        exp_q.push_back(model_result(big_t'(a), big_t'(b), big_t'(m), mp));
    endtask

    task automatic bubble();
        @(posedge i_clk);
        #DRIVE_DLY;
        i_valid    = 1'b0;
        i_operands = '0;
    endtask

    task automatic send_random();
        logic [255:0] m;
        m = rand256() | 256'd1;
        send(rand256() % m, rand256() % m, m);
    endtask

    // watchdog bounds this wait
    task automatic drain();
        bubble();
        while (exp_q.size() != 0) begin
            @(negedge i_clk);
        end
        @(negedge i_clk);
    endtask

    task automatic finish_test(input string name, input int err0);
        tests_run++;
        if (errors == err0) begin
            $display("test %0d %s: pass", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: FAIL with %0d errors", tests_run, name, errors - err0);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////
    task automatic test_idle();
        int err0;
        err0 = errors;
        repeat (IDLE_CYCLES) begin
            @(negedge i_clk);
            check_valid("o_valid", o_valid, 1'b0);
            check_result("o_result", o_result, '0);
        end
        finish_test("idle outputs", err0);
    endtask

    task automatic test_single();
        int err0;
        logic [255:0] m;
        big_t res;
        err0 = errors;
        m = 256'd1000003;
        send(256'd1, 256'd1, m);
        drain();
        res = big_t'(last_result);
        if (((res << mmm_width_pkg::R_W) % big_t'(m)) != big_t'(1)) begin
            errors++;
            $display("result times R is not congruent to a*b modulo m");
        end
        if (res >= 2 * big_t'(m)) begin
            errors++;
            $display("result is not below twice the modulus");
        end
        finish_test("single small product", err0);
    endtask

    task automatic test_edge();
        int err0;
        err0 = errors;
        send(256'd0, M_EDGE - 256'd5, M_EDGE);
        send(M_EDGE - 256'd1, M_EDGE - 256'd1, M_EDGE);
        drain();
        finish_test("zero and edge operands", err0);
    endtask

    task automatic test_random();
        int err0;
        err0 = errors;
        repeat (RAND_CNT) begin
            send_random();
        end
        drain();
        finish_test("back-to-back random", err0);
    endtask

    task automatic test_bubbles();
        int err0;
        err0 = errors;
        for (int i = 15; i >= 0; i--) begin
            if (BUBBLE_PAT[i]) begin
                send_random();
            end else begin
                bubble();
            end
        end
        drain();
        finish_test("bubble pattern", err0);
    endtask

    initial begin
        i_rstn     = 1'b0;
        i_valid    = 1'b0;
        i_operands = '0;
        repeat (RST_CYCLES) @(posedge i_clk);
        #DRIVE_DLY;
        i_rstn = 1'b1;
        test_idle();
        test_single();
        test_edge();
        test_random();
        test_bubbles();
        $display("summary: %0d tests, %0d failed, %0d check errors",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        #(WATCH_NS);
        $display("watchdog expired after %0d ns with results still outstanding", WATCH_NS);
        $display("Checks failed");
        $finish;
    end

endmodule

// ==== list.f ====
common/mmm_width_pkg.sv
common/mmm_pipe_pkg.sv
verilog/mmm_limb_mul.sv
verilog/mmm_delay_line.sv
mmm_core/mmm_product_stage.sv
mmm_core/mmm_quotient_stage.sv
mmm_core/mmm_reduce_stage.sv
mmm_core/mmm_montgomery_top.sv
verification/mmm_props.sv
verification/mmm_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the montgomery multiplier testbench with verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module mmm_tb -f list.f -o mmm_sim \
    && ./obj_dir/mmm_sim | tee /dev/stderr | grep "All checks passed" > /dev/null \
    && echo "simulation result: PASS" \
    || { echo "simulation result: FAIL"; exit 1; }
